// File: common/cache_types_pkg.sv
// cache geometry and address split for both caches.
// word, address and line field types, field extract helpers.
// icache and dcache state encodings.

package cache_types_pkg;

  // 16 sets of 2-word lines.
  localparam int WORD_W      = 32;
  localparam int BLOCK_WORDS = 2;
  localparam int NUM_SETS    = 16;

  // byte bits, word select bit, index, then tag.
  localparam int BYTE_BITS   = 2;
  localparam int WORD_BITS   = $clog2(BLOCK_WORDS);
  localparam int OFFSET_BITS = BYTE_BITS + WORD_BITS;
  localparam int INDEX_BITS  = $clog2(NUM_SETS);
  localparam int TAG_BITS    = WORD_W - OFFSET_BITS - INDEX_BITS;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [WORD_W-1:0]     addr_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [WORD_BITS-1:0]  wsel_t;

  typedef enum logic [1:0] {IC_IDLE, IC_REFILL, IC_FLUSH} icache_state_e;
  typedef enum logic [2:0] {
    DC_IDLE, DC_WRITEBACK, DC_REFILL, DC_FLUSH_SCAN, DC_FLUSH_WB
  } dcache_state_e;

  function automatic tag_t get_tag(addr_t a);
    return a[WORD_W-1 -: TAG_BITS];
  endfunction

  function automatic index_t get_index(addr_t a);
    return a[OFFSET_BITS +: INDEX_BITS];
  endfunction

  function automatic wsel_t get_wsel(addr_t a);
    return a[BYTE_BITS +: WORD_BITS];
  endfunction

endpackage

// File: common/bus_types_pkg.sv
// byte lane type for the generic word bus.
// arbiter grant states of the memory controller.

package bus_types_pkg;

  // one enable per byte lane.
  localparam int BYTES_PER_WORD = 4;
  localparam int BYTE_W         = 8;

  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

  // full-word transfer, used by refills and write-backs.
  localparam byte_en_t BYTE_EN_ALL = '1;

  // idle, or which cache holds the external bus.
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_DCACHE,
    ARB_ICACHE
  } arb_state_e;

endpackage

// File: common/generic_bus_if.sv
`timescale 1ns/100ps
// generic word bus with master and slave modports.
// busy idles high and drops for one cycle per transfer.

interface generic_bus_if;
  import cache_types_pkg::*;
  import bus_types_pkg::*;

  // request side, held stable until busy goes low.
  logic     ren;
  logic     wen;
  addr_t    addr;
  word_t    wdata;
  byte_en_t byte_en;

  // response side.
  word_t    rdata;
  logic     busy;

  modport master (
    output ren, wen, addr, wdata, byte_en,
    input  rdata, busy
  );

  modport slave (
    input  ren, wen, addr, wdata, byte_en,
    output rdata, busy
  );

endinterface

// File: caches/icache.sv
`timescale 1ns/100ps
// read-only instruction cache, direct mapped, two-word lines.
// in-order line refill and single-cycle invalidate on fence.

module icache (
  input  logic          CLK,
  input  logic          rst_n,
  generic_bus_if.slave  proc,
  generic_bus_if.master mem,
  input  logic          fence_start,
  output logic          flush_done,
  output logic          miss
);
  import cache_types_pkg::*;
  import bus_types_pkg::*;

  // line storage, valid bits only are cleared.
  word_t               data_arr [NUM_SETS][BLOCK_WORDS];
  tag_t                tag_arr  [NUM_SETS];
  logic [NUM_SETS-1:0] valid;

  icache_state_e state;
  wsel_t         refill_word;

  index_t idx;
  tag_t   tag;
  wsel_t  wsel;
  logic   hit;
  logic   last_word;
  logic   fill_we;

  // request address is held by the fetch side for the whole miss.
  assign idx  = get_index(proc.addr);
  assign tag  = get_tag(proc.addr);
  assign wsel = get_wsel(proc.addr);
  assign hit  = valid[idx] && (tag_arr[idx] == tag);

  // hits answer in the request cycle.
  assign proc.busy  = !((state == IC_IDLE) && proc.ren && hit);
  assign proc.rdata = data_arr[idx][wsel];

  // refill reads the line word by word, lowest first.
  assign mem.ren     = (state == IC_REFILL);
  assign mem.wen     = 1'b0;
  assign mem.addr    = {tag, idx, refill_word, {BYTE_BITS{1'b0}}};
  assign mem.wdata   = '0;
  assign mem.byte_en = BYTE_EN_ALL;

  assign last_word  = (refill_word == wsel_t'(BLOCK_WORDS - 1));
  assign fill_we    = (state == IC_REFILL) && !mem.busy;
  assign miss       = (state == IC_REFILL);
  assign flush_done = (state == IC_FLUSH);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state       <= IC_IDLE;
      valid       <= '0;
      refill_word <= '0;
    end else begin
      case (state)
        IC_IDLE: begin
          refill_word <= '0;
          if (fence_start) begin
            state <= IC_FLUSH;
          end else if (proc.ren && !hit) begin
            state <= IC_REFILL;
          end
        end
        IC_REFILL: begin
          if (fill_we) begin
            refill_word <= refill_word + 1'b1;
            // line becomes visible once both words are in.
            if (last_word) begin
              valid[idx] <= 1'b1;
              state      <= IC_IDLE;
            end
          end
        end
        IC_FLUSH: begin
          valid <= '0;
          state <= IC_IDLE;
        end
        default: state <= IC_IDLE;
      endcase
    end
  end

  // data and tags, written during refill.
  always_ff @(posedge CLK) begin
    if (fill_we) begin
      data_arr[idx][refill_word] <= mem.rdata;
      if (last_word) begin
        tag_arr[idx] <= tag;
      end
    end
  end

  // fetch side never stores.
  a_no_proc_write: assert property (@(posedge CLK) disable iff (!rst_n) !proc.wen)
    else $error("icache: write request on fetch bus");

endmodule

// File: caches/dcache.sv
`timescale 1ns/100ps
// write-back, write-allocate data cache, direct mapped.
// byte-enabled stores, dirty victim eviction, fence flush of all sets.

module dcache (
  input  logic          CLK,
  input  logic          rst_n,
  generic_bus_if.slave  proc,
  generic_bus_if.master mem,
  input  logic          fence_start,
  output logic          flush_done,
  output logic          miss
);
  import cache_types_pkg::*;
  import bus_types_pkg::*;

  // line storage and per-line status.
  word_t               data_arr [NUM_SETS][BLOCK_WORDS];
  tag_t                tag_arr  [NUM_SETS];
  logic [NUM_SETS-1:0] valid;
  logic [NUM_SETS-1:0] dirty;

  dcache_state_e state;
  wsel_t         word_cnt;
  index_t        scan_idx;

  index_t idx;
  index_t line_idx;
  tag_t   tag;
  wsel_t  wsel;
  logic   req;
  logic   hit;
  logic   flushing;
  logic   victim_dirty;
  logic   last_word;
  logic   mem_done;
  logic   store_we;
  logic   fill_we;

  assign idx  = get_index(proc.addr);
  assign tag  = get_tag(proc.addr);
  assign wsel = get_wsel(proc.addr);
  assign req  = proc.ren || proc.wen;
  assign hit  = valid[idx] && (tag_arr[idx] == tag);

  // flush walks scan_idx, otherwise the set of the request.
  assign flushing     = (state == DC_FLUSH_SCAN) || (state == DC_FLUSH_WB);
  assign line_idx     = flushing ? scan_idx : idx;
  assign victim_dirty = valid[line_idx] && dirty[line_idx];
  assign last_word    = (word_cnt == wsel_t'(BLOCK_WORDS - 1));
  assign mem_done     = !mem.busy;

  // hits finish in the request cycle, stores merge at the edge.
  assign proc.busy  = !((state == DC_IDLE) && req && hit);
  assign proc.rdata = data_arr[idx][wsel];
  assign store_we   = (state == DC_IDLE) && proc.wen && hit;
  assign fill_we    = (state == DC_REFILL) && mem_done;

  // refill uses the new tag, write-back the stored victim tag.
  assign mem.ren     = (state == DC_REFILL);
  assign mem.wen     = (state == DC_WRITEBACK) || (state == DC_FLUSH_WB);
  assign mem.addr    = {(state == DC_REFILL) ? tag : tag_arr[line_idx], line_idx, word_cnt,
                        {BYTE_BITS{1'b0}}};
  assign mem.wdata   = data_arr[line_idx][word_cnt];
  assign mem.byte_en = BYTE_EN_ALL;

  assign miss       = (state == DC_WRITEBACK) || (state == DC_REFILL);
  // pulses when the last set scans clean.
  assign flush_done = (state == DC_FLUSH_SCAN) && !victim_dirty &&
                      (scan_idx == index_t'(NUM_SETS - 1));

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= DC_IDLE;
      valid    <= '0;
      dirty    <= '0;
      word_cnt <= '0;
      scan_idx <= '0;
    end else begin
      case (state)
        DC_IDLE: begin
          word_cnt <= '0;
          scan_idx <= '0;
          if (fence_start) begin
            state <= DC_FLUSH_SCAN;
          end else if (req && !hit) begin
            state <= victim_dirty ? DC_WRITEBACK : DC_REFILL;
          end else if (store_we) begin
            dirty[idx] <= 1'b1;
          end
        end
        DC_WRITEBACK: begin
          // counter wraps to word 0 for the refill.
          if (mem_done) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) state <= DC_REFILL;
          end
        end
        DC_REFILL: begin
          if (mem_done) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
              valid[idx] <= 1'b1;
              dirty[idx] <= 1'b0;
              state      <= DC_IDLE;
            end
          end
        end
        DC_FLUSH_SCAN: begin
          word_cnt <= '0;
          if (victim_dirty) begin
            state <= DC_FLUSH_WB;
          end else begin
            valid[scan_idx] <= 1'b0;
            if (scan_idx == index_t'(NUM_SETS - 1)) state <= DC_IDLE;
            else scan_idx <= scan_idx + 1'b1;
          end
        end
        DC_FLUSH_WB: begin
          // set is rescanned clean, then invalidated.
          if (mem_done) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
              dirty[scan_idx] <= 1'b0;
              state           <= DC_FLUSH_SCAN;
            end
          end
        end
        default: state <= DC_IDLE;
      endcase
    end
  end

  // refill words, or store bytes merged under byte_en.
  always_ff @(posedge CLK) begin
    if (fill_we) begin
      data_arr[idx][word_cnt] <= mem.rdata;
      if (last_word) tag_arr[idx] <= tag;
    end else if (store_we) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (proc.byte_en[b]) begin
          data_arr[idx][wsel][BYTE_W*b +: BYTE_W] <= proc.wdata[BYTE_W*b +: BYTE_W];
        end
      end
    end
  end

  a_proc_one_dir: assert property (@(posedge CLK) disable iff (!rst_n) !(proc.ren && proc.wen))
    else $error("dcache: load and store requested together");

endmodule

// File: caches/separate_caches.sv
`timescale 1ns/100ps
// instruction and data cache pair with fence sequencing.
// fence_done waits for both flush reports.

module separate_caches (
  input  logic          CLK,
  input  logic          rst_n,
  generic_bus_if.slave  icache_proc,
  generic_bus_if.slave  dcache_proc,
  generic_bus_if.master icache_mem,
  generic_bus_if.master dcache_mem,
  input  logic          fence,
  output logic          fence_done,
  output logic          icache_miss,
  output logic          dcache_miss
);

  logic fence_start;
  logic fence_active;
  logic ic_flush_done;
  logic dc_flush_done;
  logic ic_seen;
  logic dc_seen;
  logic ic_done_now;
  logic dc_done_now;
  logic all_done;

  // a second pulse during a flush is dropped.
  assign fence_start = fence && !fence_active;

  // icache usually reports first and is held here.
  assign ic_done_now = ic_seen || ic_flush_done;
  assign dc_done_now = dc_seen || dc_flush_done;
  assign all_done    = fence_active && ic_done_now && dc_done_now;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      fence_active <= 1'b0;
      ic_seen      <= 1'b0;
      dc_seen      <= 1'b0;
      fence_done   <= 1'b0;
    end else begin
      fence_done <= all_done;
      if (fence_start) begin
        fence_active <= 1'b1;
      end else if (all_done) begin
        fence_active <= 1'b0;
      end
      ic_seen <= ic_done_now && !all_done;
      dc_seen <= dc_done_now && !all_done;
    end
  end

  icache icache_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .proc        (icache_proc),
    .mem         (icache_mem),
    .fence_start (fence_start),
    .flush_done  (ic_flush_done),
    .miss        (icache_miss)
  );

  dcache dcache_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .proc        (dcache_proc),
    .mem         (dcache_mem),
    .fence_start (fence_start),
    .flush_done  (dc_flush_done),
    .miss        (dcache_miss)
  );

endmodule

// File: rtl/memory_controller.sv
`timescale 1ns/100ps
// two-master arbiter from the cache memory buses onto the external bus.
// grant per word transfer, data cache first.

module memory_controller (
  input  logic                     CLK,
  input  logic                     rst_n,
  generic_bus_if.slave             icache_mem,
  generic_bus_if.slave             dcache_mem,
  output logic                     mem_ren,
  output logic                     mem_wen,
  output cache_types_pkg::addr_t   mem_addr,
  output cache_types_pkg::word_t   mem_wdata,
  output bus_types_pkg::byte_en_t  mem_byte_en,
  input  cache_types_pkg::word_t   mem_rdata,
  input  logic                     mem_busy
);
  import bus_types_pkg::*;

  arb_state_e state;
  arb_state_e gnt;
  logic       d_req;
  logic       i_req;

  assign d_req = dcache_mem.ren || dcache_mem.wen;
  assign i_req = icache_mem.ren || icache_mem.wen;

  // idle grants at once, so no cycle is added.
  always_comb begin
    gnt = state;
    if (state == ARB_IDLE) begin
      if (d_req) begin
        gnt = ARB_DCACHE;
      end else if (i_req) begin
        gnt = ARB_ICACHE;
      end
    end
  end

  // granted master goes straight out.
  always_comb begin
    mem_ren     = 1'b0;
    mem_wen     = 1'b0;
    mem_addr    = '0;
    mem_wdata   = '0;
    mem_byte_en = '0;
    case (gnt)
      ARB_DCACHE: begin
        mem_ren     = dcache_mem.ren;
        mem_wen     = dcache_mem.wen;
        mem_addr    = dcache_mem.addr;
        mem_wdata   = dcache_mem.wdata;
        mem_byte_en = dcache_mem.byte_en;
      end
      ARB_ICACHE: begin
        mem_ren     = icache_mem.ren;
        mem_wen     = icache_mem.wen;
        mem_addr    = icache_mem.addr;
        mem_wdata   = icache_mem.wdata;
        mem_byte_en = icache_mem.byte_en;
      end
      default: ;
    endcase
  end

  // only the granted master sees busy drop.
  assign dcache_mem.rdata = mem_rdata;
  assign icache_mem.rdata = mem_rdata;
  assign dcache_mem.busy  = !((gnt == ARB_DCACHE) && !mem_busy);
  assign icache_mem.busy  = !((gnt == ARB_ICACHE) && !mem_busy);

  // hold until the word completes, release the cycle after.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
    end else begin
      state <= ((gnt != ARB_IDLE) && mem_busy) ? gnt : ARB_IDLE;
    end
  end

  // each cache bus carries one direction at a time.
  a_one_dir: assert property (@(posedge CLK) disable iff (!rst_n)
    !(dcache_mem.ren && dcache_mem.wen) && !(icache_mem.ren && icache_mem.wen))
    else $error("memory_controller: read and write requested together on a cache bus");

endmodule

// File: rtl/supervisor_cache_top.sv
`timescale 1ns/100ps
// top level of the cache subsystem.
// plain processor and memory ports onto the internal word buses.

module supervisor_cache_top (
  input  logic                     CLK,
  input  logic                     rst_n,
  // fetch port.
  input  logic                     i_ren,
  input  cache_types_pkg::addr_t   i_addr,
  output cache_types_pkg::word_t   i_rdata,
  output logic                     i_busy,
  // load/store port.
  input  logic                     d_ren,
  input  logic                     d_wen,
  input  cache_types_pkg::addr_t   d_addr,
  input  cache_types_pkg::word_t   d_wdata,
  input  bus_types_pkg::byte_en_t  d_byte_en,
  output cache_types_pkg::word_t   d_rdata,
  output logic                     d_busy,
  // fence and status.
  input  logic                     fence,
  output logic                     fence_done,
  output logic                     icache_miss,
  output logic                     dcache_miss,
  // external word bus.
  output logic                     mem_ren,
  output logic                     mem_wen,
  output cache_types_pkg::addr_t   mem_addr,
  output cache_types_pkg::word_t   mem_wdata,
  output bus_types_pkg::byte_en_t  mem_byte_en,
  input  cache_types_pkg::word_t   mem_rdata,
  input  logic                     mem_busy
);
  import bus_types_pkg::*;

  generic_bus_if icache_proc_bus ();
  generic_bus_if dcache_proc_bus ();
  generic_bus_if icache_mem_bus ();
  generic_bus_if dcache_mem_bus ();

  // fetch is read only, full word.
  assign icache_proc_bus.ren     = i_ren;
  assign icache_proc_bus.wen     = 1'b0;
  assign icache_proc_bus.addr    = i_addr;
  assign icache_proc_bus.wdata   = '0;
  assign icache_proc_bus.byte_en = BYTE_EN_ALL;
  assign i_rdata                 = icache_proc_bus.rdata;
  assign i_busy                  = icache_proc_bus.busy;

  assign dcache_proc_bus.ren     = d_ren;
  assign dcache_proc_bus.wen     = d_wen;
  assign dcache_proc_bus.addr    = d_addr;
  assign dcache_proc_bus.wdata   = d_wdata;
  assign dcache_proc_bus.byte_en = d_byte_en;
  assign d_rdata                 = dcache_proc_bus.rdata;
  assign d_busy                  = dcache_proc_bus.busy;

  separate_caches caches (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .icache_proc (icache_proc_bus),
    .dcache_proc (dcache_proc_bus),
    .icache_mem  (icache_mem_bus),
    .dcache_mem  (dcache_mem_bus),
    .fence       (fence),
    .fence_done  (fence_done),
    .icache_miss (icache_miss),
    .dcache_miss (dcache_miss)
  );

  memory_controller mem_ctrl (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .icache_mem  (icache_mem_bus),
    .dcache_mem  (dcache_mem_bus),
    .mem_ren     (mem_ren),
    .mem_wen     (mem_wen),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_byte_en (mem_byte_en),
    .mem_rdata   (mem_rdata),
    .mem_busy    (mem_busy)
  );

endmodule

// File: verif/tb_supervisor_cache.sv
`timescale 1ns/100ps
// testbench for the cache subsystem top level.
// clock, reset, external memory model with random latency,
// pattern replay from a data file, checks and a closing summary.

module tb_supervisor_cache;
  import cache_types_pkg::*;
  import bus_types_pkg::*;

  localparam int    COLS      = 7;
  localparam int    MAX_LINES = 64;
  localparam int    TIMEOUT   = 200;
  localparam word_t RULE_KEY  = 32'h5A5A_0000;

  // pattern opcodes.
  localparam int OP_FETCH = 0;
  localparam int OP_LOAD  = 1;
  localparam int OP_STORE = 2;
  localparam int OP_FENCE = 3;
  localparam int OP_BOTH  = 4;

  logic     clk;
  logic     rst_n;
  logic     i_ren;
  addr_t    i_addr;
  word_t    i_rdata;
  logic     i_busy;
  logic     d_ren;
  logic     d_wen;
  addr_t    d_addr;
  word_t    d_wdata;
  byte_en_t d_byte_en;
  word_t    d_rdata;
  logic     d_busy;
  logic     fence;
  logic     fence_done;
  logic     icache_miss;
  logic     dcache_miss;
  logic     mem_ren;
  logic     mem_wen;
  addr_t    mem_addr;
  word_t    mem_wdata;
  byte_en_t mem_byte_en;
  word_t    mem_rdata;
  logic     mem_busy;

  // external memory contents, and the word values the processor should see.
  word_t       shadow    [addr_t];
  word_t       cpu_model [addr_t];
  logic [31:0] pat       [0:COLS*MAX_LINES-1];

  integer seed             = 83789;
  int     countdown        = 0;
  logic   next_busy        = 1'b1;
  word_t  next_rdata       = '0;
  int     ext_writes       = 0;
  int     mem_value_errors = 0;
  int     mem_other_errors = 0;
  int     value_errors;
  int     other_errors;
  logic   timed_out;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  supervisor_cache_top i_dut (
    .CLK (clk), .rst_n (rst_n),
    .i_ren (i_ren), .i_addr (i_addr), .i_rdata (i_rdata), .i_busy (i_busy),
    .d_ren (d_ren), .d_wen (d_wen), .d_addr (d_addr), .d_wdata (d_wdata),
    .d_byte_en (d_byte_en), .d_rdata (d_rdata), .d_busy (d_busy),
    .fence (fence), .fence_done (fence_done),
    .icache_miss (icache_miss), .dcache_miss (dcache_miss),
    .mem_ren (mem_ren), .mem_wen (mem_wen), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_byte_en (mem_byte_en),
    .mem_rdata (mem_rdata), .mem_busy (mem_busy)
  );

  // initial memory word at a byte address.
  function automatic word_t rule_word(addr_t a);
    return a ^ RULE_KEY;
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
    word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  function automatic word_t memory_word(addr_t a);
    return shadow.exists(a) ? shadow[a] : rule_word(a);
  endfunction

  function automatic word_t expected_word(addr_t a);
    return cpu_model.exists(a) ? cpu_model[a] : rule_word(a);
  endfunction

  // a write-back must carry the newest processor value of its word.
  task automatic record_write(addr_t a, word_t d, byte_en_t be);
    word_t exp_w;
    exp_w = expected_word(a);
    ext_writes++;
    if (d !== exp_w) begin
      mem_value_errors++;
      $display("error mem_wdata at %h: got %h expected %h", a, d, exp_w);
    end
    shadow[a] = merge_bytes(memory_word(a), d, be);
  endtask

  // memory decisions at mid cycle, where the bus is settled.
  always @(negedge clk) begin
    if (!rst_n) begin
      countdown = 0;
      next_busy = 1'b1;
    end else if (!mem_busy) begin
      // refills and write-backs move whole words.
      if (mem_byte_en !== 4'hF) begin
        mem_value_errors++;
        $display("error mem_byte_en at %h: got %h expected %h", mem_addr, mem_byte_en, 4'hF);
      end
      // word completes at the coming edge.
      if (mem_wen) record_write(mem_addr, mem_wdata, mem_byte_en);
      countdown = 0;
      next_busy = 1'b1;
    end else if (mem_ren || mem_wen) begin
      // a fresh request waits 1 to 4 cycles.
      if (countdown == 0) countdown = 1 + ($unsigned($random(seed)) % 4);
      countdown = countdown - 1;
      if (countdown == 0) begin
        next_busy  = 1'b0;
        next_rdata = mem_ren ? memory_word(mem_addr) : '0;
      end
    end
    if (mem_ren && mem_wen) begin
      mem_other_errors++;
      $display("external bus shows a read and a write together at %0t", $time);
    end
  end

  // memory outputs follow the rising edge.
  initial begin
    mem_busy  = 1'b1;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_busy  = next_busy;
      mem_rdata = next_rdata;
    end
  end

  task automatic check_word(string name, int idx, word_t got, word_t exp_w);
    if (got !== exp_w) begin
      value_errors++;
      $display("error %s on pattern %0d: got %h expected %h", name, idx, got, exp_w);
    end
  endtask

  task automatic check_miss(string name, int idx, logic saw, int lat, int mode);
    if (mode == 0 && (saw || lat != 0)) begin
      other_errors++;
      $display("pattern %0d should hit, but %s rose or busy stayed high", idx, name);
    end else if (mode == 1 && !saw) begin
      other_errors++;
      $display("pattern %0d should miss, but %s never rose", idx, name);
    end
  endtask

  // fetch, load, store, or fetch and load at once.
  task automatic run_access(int idx, int op, addr_t a, word_t wd, byte_en_t be,
                            word_t exp_w, int mode);
    logic use_i;
    logic use_d;
    logic i_done;
    logic d_done;
    logic saw_i;
    logic saw_d;
    int   i_lat;
    int   d_lat;
    int   cycles;
    use_i  = (op == OP_FETCH) || (op == OP_BOTH);
    use_d  = (op == OP_LOAD) || (op == OP_STORE) || (op == OP_BOTH);
    i_done = !use_i;
    d_done = !use_d;
    saw_i  = 1'b0;
    saw_d  = 1'b0;
    i_lat  = 0;
    d_lat  = 0;
    cycles = 0;
    @(posedge clk);
    #1;
    i_ren     = use_i;
    i_addr    = a;
    d_ren     = use_d && (op != OP_STORE);
    d_wen     = (op == OP_STORE);
    d_addr    = a;
    d_wdata   = wd;
    d_byte_en = be;
    while (!(i_done && d_done) && cycles < TIMEOUT) begin
      @(negedge clk);
      saw_i = saw_i || icache_miss;
      saw_d = saw_d || dcache_miss;
      if (!i_done && !i_busy) begin
        i_done = 1'b1;
        i_lat  = cycles;
        check_word("i_rdata", idx, i_rdata, exp_w);
      end
      if (!d_done && !d_busy) begin
        d_done = 1'b1;
        d_lat  = cycles;
        if (op == OP_STORE) cpu_model[a] = merge_bytes(expected_word(a), wd, be);
        else check_word("d_rdata", idx, d_rdata, exp_w);
      end
      @(posedge clk);
      #1;
      // each side drops its request once served.
      if (i_done) i_ren = 1'b0;
      if (d_done) begin
        d_ren = 1'b0;
        d_wen = 1'b0;
      end
      cycles++;
    end
    if (!(i_done && d_done)) begin
      timed_out = 1'b1;
      other_errors++;
      $display("timeout on pattern %0d, the request was never answered", idx);
    end else begin
      if (use_i) check_miss("icache_miss", idx, saw_i, i_lat, mode);
      if (use_d) check_miss("dcache_miss", idx, saw_d, d_lat, mode);
    end
  endtask

  task automatic run_fence(int idx);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    @(posedge clk);
    #1;
    fence = 1'b1;
    @(posedge clk);
    #1;
    fence = 1'b0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      seen = fence_done;
      cycles++;
    end
    if (!seen) begin
      timed_out = 1'b1;
      other_errors++;
      $display("timeout on pattern %0d, fence_done never pulsed", idx);
    end else begin
      @(negedge clk);
      if (fence_done) begin
        other_errors++;
        $display("fence_done stayed high for more than one cycle on pattern %0d", idx);
      end
    end
  endtask

  initial begin
    int       k;
    int       n;
    int       base;
    int       op;
    int       mode;
    int       exp_writes;
    int       writes_before;
    addr_t    a;
    word_t    wd;
    word_t    exp_w;
    word_t    predicted;
    byte_en_t be;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    rst_n        = 1'b0;
    i_ren        = 1'b0;
    i_addr       = '0;
    d_ren        = 1'b0;
    d_wen        = 1'b0;
    d_addr       = '0;
    d_wdata      = '0;
    d_byte_en    = '0;
    fence        = 1'b0;
    for (k = 0; k < COLS*MAX_LINES; k++) pat[k] = '1;
    $readmemh("verif/cache_patterns.txt", pat);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // quiet state right after reset.
    @(negedge clk);
    check_word("mem_ren", 0, {31'b0, mem_ren}, 32'h0);
    check_word("mem_wen", 0, {31'b0, mem_wen}, 32'h0);
    check_word("icache_miss", 0, {31'b0, icache_miss}, 32'h0);
    check_word("dcache_miss", 0, {31'b0, dcache_miss}, 32'h0);
    check_word("fence_done", 0, {31'b0, fence_done}, 32'h0);
    check_word("i_busy", 0, {31'b0, i_busy}, 32'h1);
    check_word("d_busy", 0, {31'b0, d_busy}, 32'h1);
    if (pat[0] == 32'hFFFF_FFFF) begin
      other_errors++;
      $display("no patterns were read from the data file");
    end
    n = 0;
    while (!timed_out && n < MAX_LINES && pat[n*COLS] != 32'hFFFF_FFFF) begin
      base       = n * COLS;
      op         = pat[base];
      a          = pat[base+1];
      wd         = pat[base+2];
      be         = pat[base+3][3:0];
      exp_w      = pat[base+4];
      mode       = pat[base+5];
      exp_writes = pat[base+6];
      // the data file must agree with the memory rule and earlier stores.
      predicted = (op == OP_STORE) ? merge_bytes(expected_word(a), wd, be) : expected_word(a);
      if (op != OP_FENCE && predicted !== exp_w) begin
        other_errors++;
        $display("pattern %0d expects %h but the store model gives %h", n, exp_w, predicted);
      end
      writes_before = ext_writes;
      if (op == OP_FENCE) run_fence(n);
      else if (op >= OP_FETCH && op <= OP_BOTH) run_access(n, op, a, wd, be, exp_w, mode);
      else begin
        other_errors++;
        $display("pattern %0d has an unknown operation", n);
      end
      if (!timed_out && ext_writes - writes_before != exp_writes) begin
        other_errors++;
        $display("pattern %0d saw %0d external writes instead of %0d", n,
                 ext_writes - writes_before, exp_writes);
      end
      n++;
    end
    value_errors = value_errors + mem_value_errors;
    other_errors = other_errors + mem_other_errors;
    $display("summary: %0d patterns, %0d value errors, %0d other failures",
             n, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verif/cache_patterns.txt
// columns: op addr wdata byte_en expected miss writes (all hex).
// op 0 fetch, 1 load, 2 store, 3 fence, 4 fetch and load of one address.
// expected is the read value, or the merged word after a store.
// miss 0 hit, 1 miss. writes is the external write count of the op.
// fetch miss, neighbor word hit, first word hit.
0 00001000 00000000 f 5a5a1000 1 0
0 00001004 00000000 f 5a5a1004 0 0
0 00001000 00000000 f 5a5a1000 0 0
// load miss, partial stores and reloads, no external write.
1 00002010 00000000 f 5a5a2010 1 0
2 00002010 11223344 3 5a5a3344 0 0
1 00002010 00000000 f 5a5a3344 0 0
2 00002014 aabbccdd c aabb2014 0 0
1 00002014 00000000 f aabb2014 0 0
// conflicting load evicts the dirty set 2 line.
1 00002090 00000000 f 5a5a2090 1 2
1 00002010 00000000 f 5a5a3344 1 0
// store miss allocates the line.
2 00003028 0000beef 3 5a5abeef 1 0
1 00003028 00000000 f 5a5abeef 0 0
// three dirty lines, then fence.
2 00002010 01020304 f 01020304 0 0
2 00004040 cafef00d f cafef00d 1 0
3 00000000 00000000 0 00000000 0 6
// everything misses again after the fence.
0 00001000 00000000 f 5a5a1000 1 0
1 00002014 00000000 f aabb2014 1 0
1 00003028 00000000 f 5a5abeef 1 0
1 00004040 00000000 f cafef00d 1 0
// both caches miss together under random latency.
4 00005000 00000000 f 5a5a5000 1 0
4 00006184 00000000 f 5a5a6184 1 0
2 00006180 13579bdf f 13579bdf 0 0
4 00007004 00000000 f 5a5a7004 1 2
4 00006180 00000000 f 13579bdf 1 0
0 00006184 00000000 f 5a5a6184 0 0
// clean fence, fetch sees the written back word.
3 00000000 00000000 0 00000000 0 0
0 00006180 00000000 f 13579bdf 1 0

// File: list.f
common/cache_types_pkg.sv
common/bus_types_pkg.sv
common/generic_bus_if.sv
caches/icache.sv
caches/dcache.sv
caches/separate_caches.sv
rtl/memory_controller.sv
rtl/supervisor_cache_top.sv
verif/tb_supervisor_cache.sv

// File: run_sim.sh
#!/bin/sh
# build the cache subsystem testbench with Verilator and run it.
# the run passes only if the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
        --top-module tb_supervisor_cache -f list.f \
      && ./obj_dir/Vtb_supervisor_cache) || { echo "$out"; echo "build or run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
